// File: common/alu6502_pkg.sv
// alu6502 shared definitions
// Operation codes of the decimal-capable ALU, the decimal digit type and
// the per-digit carry and correction constants used by the adder and the
// result stage
`default_nettype none

package alu6502_pkg;

    // Operation codes, top two bits set selects the logic path
    typedef enum logic [3:0] {
        OP_ADD = 4'b0011,       // A + B + ci
        OP_SUB = 4'b0111,       // A + ~B + ci
        OP_SHR = 4'b1000,       // Shift A right, ci into top bit
        OP_ROL = 4'b1011,       // A + A + ci, shift left through adder
        OP_OR  = 4'b1100,       // A | B
        OP_AND = 4'b1101,       // A & B
        OP_EOR = 4'b1110,       // A ^ B
        OP_A   = 4'b1111        // Pass A through
    } alu_op_t;

    // One decimal digit is one nibble
    localparam int NIBBLE_W = 4;

    typedef logic [NIBBLE_W-1:0] digit_t;

    // Digit sum at or above this forces a carry in decimal add
    localparam int DIGIT_CARRY_LIMIT = 10;

    // Per-digit correction terms, applied modulo sixteen
    localparam digit_t ADD_FIX = 4'd6;      // Decimal add, digit carried
    localparam digit_t SUB_FIX = 4'd10;     // Decimal subtract, digit borrowed

endpackage

`default_nettype wire

// File: hdl/logic_unit.sv
// ALU logic unit
// Bitwise OR, AND and EOR of the two operands, pass-through of A, and the
// right shift of A with the carry input filled into the top bit. Purely
// combinational; clk and reset only qualify the operation code check.
`timescale 1ns/10ps
`default_nettype none

module logic_unit import alu6502_pkg::*; #(
    parameter int DIGITS = 2                    // Decimal digits per operand
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [DIGITS*NIBBLE_W-1:0]   a,
    input  logic [DIGITS*NIBBLE_W-1:0]   b,
    input  alu_op_t                      op,
    input  logic                         ci,
    output logic [DIGITS*NIBBLE_W-1:0]   logic_result,
    output logic                         shift_carry
);

    localparam int W = DIGITS * NIBBLE_W;

    always_comb begin
        shift_carry = 1'b0;                     // Only a right shift moves a bit out
        case (op)
            OP_OR:   logic_result = a | b;
            OP_AND:  logic_result = a & b;
            OP_EOR:  logic_result = a ^ b;
            OP_A:    logic_result = a;
            OP_SHR: begin
                logic_result = {ci, a[W-1:1]};  // ROR with ci, LSR with ci=0
                shift_carry  = a[0];            // Bottom bit becomes the carry
            end
            default: logic_result = a;          // Adder codes, value not used
        endcase
    end

    // Caller must present one of the defined operation codes
    op_known: assert property (
        @(posedge clk) disable iff (reset)
        op inside {OP_ADD, OP_SUB, OP_SHR, OP_ROL, OP_OR, OP_AND, OP_EOR, OP_A}
    ) else $error("logic_unit: unknown operation code %b", op);

endmodule

`default_nettype wire

// File: decimal_adder/decimal_adder.sv
// Decimal-capable adder
// Adds A to the effective second operand one nibble at a time, so each
// digit carry is visible to the result stage. In decimal add a digit sum
// of ten or more forces that digit's carry, as the half carry does on the
// original processor. The raw sum leaves uncorrected.
`timescale 1ns/10ps
`default_nettype none

module decimal_adder import alu6502_pkg::*; #(
    parameter int DIGITS = 2                    // 2 or 4 digits supported
) (
    input  logic [DIGITS*NIBBLE_W-1:0]   a,
    input  logic [DIGITS*NIBBLE_W-1:0]   b,
    input  logic                         ci,
    input  alu_op_t                      op,
    input  logic                         decimal,
    output logic [DIGITS*NIBBLE_W-1:0]   sum,
    output logic                         carry_out,
    output logic [DIGITS-1:0]            digit_carry,
    output logic                         b_msb
);

    localparam int W = DIGITS * NIBBLE_W;

    logic [W-1:0] b_eff;                        // Second operand after op select
    logic         dec_add;                      // Decimal carry rule active

    if (DIGITS != 2 && DIGITS != 4) begin : g_bad_digits
        $error("decimal_adder: DIGITS must be 2 or 4");
    end

    // Second operand select
    always_comb begin
        case (op)
            OP_ADD:  b_eff = b;
            OP_SUB:  b_eff = ~b;                // Subtract as A + ~B + ci
            OP_ROL:  b_eff = a;                 // A + A shifts left
            default: b_eff = '0;                // Logic codes add nothing
        endcase
    end

    assign b_msb   = b_eff[W-1];
    // Only ADC gets the forced digit carry, SBC relies on borrows
    assign dec_add = decimal && (op == OP_ADD);

    // Nibble chain, digit carry feeds the next digit
    always_comb begin
        logic [NIBBLE_W:0] dsum;
        logic              chain;
        digit_t            a_dig;
        digit_t            b_dig;

        chain       = ci;
        sum         = '0;
        digit_carry = '0;
        for (int i = 0; i < DIGITS; i++) begin
            a_dig = a[i*NIBBLE_W +: NIBBLE_W];
            b_dig = b_eff[i*NIBBLE_W +: NIBBLE_W];
            dsum  = {1'b0, a_dig} + {1'b0, b_dig} + {{NIBBLE_W{1'b0}}, chain};
            // Binary carry, or a decimal digit of ten and up
            chain = dsum[NIBBLE_W] |
                    (dec_add && (dsum >= (NIBBLE_W+1)'(DIGIT_CARRY_LIMIT)));
            sum[i*NIBBLE_W +: NIBBLE_W] = dsum[NIBBLE_W-1:0];
            digit_carry[i] = chain;
        end
        carry_out = chain;                      // Top digit carry is the ALU carry
    end

endmodule

`default_nettype wire

// File: result_stage/result_stage.sv
// ALU result stage
// Picks the logic or adder result, registers it with the carries, the
// decimal correction mode and the operand sign bits while rdy is high,
// then applies the per-digit decimal correction and forms N, Z, C and V
// from the registered values.
`timescale 1ns/10ps
`default_nettype none

module result_stage import alu6502_pkg::*; #(
    parameter int DIGITS = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rdy,
    input  alu_op_t                      op,
    input  logic                         decimal,
    input  logic                         a_msb,
    input  logic [DIGITS*NIBBLE_W-1:0]   logic_result,
    input  logic                         shift_carry,
    input  logic [DIGITS*NIBBLE_W-1:0]   sum,
    input  logic                         carry_out,
    input  logic [DIGITS-1:0]            digit_carry,
    input  logic                         b_msb,
    output logic [DIGITS*NIBBLE_W-1:0]   result,
    output logic                         c,
    output logic                         z,
    output logic                         n,
    output logic                         v
);

    localparam int W = DIGITS * NIBBLE_W;

    typedef enum logic [1:0] {
        CORR_NONE = 2'b00,
        CORR_ADD  = 2'b01,                      // Decimal ADC
        CORR_SUB  = 2'b10                       // Decimal SBC
    } corr_mode_t;

    logic             logic_path;               // Result comes from logic unit
    logic [W-1:0]     raw_d;
    logic             carry_d;
    corr_mode_t       mode_d;

    logic [W-1:0]     raw_q;                    // Uncorrected result
    logic             carry_q;
    logic [DIGITS-1:0] dcarry_q;                // Per-digit carries
    corr_mode_t       mode_q;
    logic             a_msb_q;
    logic             b_msb_q;                  // Sign of effective second operand

    // Logic codes have both top bits set, plus the right shift
    assign logic_path = (op[3:2] == 2'b11) || (op == OP_SHR);

    always_comb begin
        raw_d   = logic_path ? logic_result : sum;
        carry_d = logic_path ? shift_carry : carry_out;
        if (decimal && op == OP_ADD) begin
            mode_d = CORR_ADD;
        end else if (decimal && op == OP_SUB) begin
            mode_d = CORR_SUB;
        end else begin
            mode_d = CORR_NONE;
        end
    end

    // Pipeline register, frozen while rdy is low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raw_q    <= '0;
            carry_q  <= 1'b0;
            dcarry_q <= '0;
            mode_q   <= CORR_NONE;
            a_msb_q  <= 1'b0;
            b_msb_q  <= 1'b0;
        end else if (rdy) begin
            raw_q    <= raw_d;
            carry_q  <= carry_d;
            dcarry_q <= digit_carry;
            mode_q   <= mode_d;
            a_msb_q  <= a_msb;
            b_msb_q  <= b_msb;
        end
    end

    // Decimal correction per digit, wraps modulo sixteen
    always_comb begin
        digit_t fix;

        for (int i = 0; i < DIGITS; i++) begin
            if (mode_q == CORR_ADD && dcarry_q[i]) begin
                fix = ADD_FIX;
            end else if (mode_q == CORR_SUB && !dcarry_q[i]) begin
                fix = SUB_FIX;                  // Borrowed digit, subtract six
            end else begin
                fix = '0;
            end
            result[i*NIBBLE_W +: NIBBLE_W] = raw_q[i*NIBBLE_W +: NIBBLE_W] + fix;
        end
    end

    // Flags from the registered, uncorrected value
    assign c = carry_q;
    assign z = ~|raw_q;
    assign n = raw_q[W-1];
    assign v = a_msb_q ^ b_msb_q ^ carry_q ^ raw_q[W-1];   // Carry into top bit xor out

    // Stall holds every output for the next cycle
    stall_holds: assert property (
        @(posedge clk) disable iff (reset)
        !rdy |=> $stable(result) && $stable(c) && $stable(z) && $stable(n) && $stable(v)
    ) else $error("result_stage: outputs changed during stall");

    // Decimal mode only makes sense on the adder path
    decimal_on_adder: assert property (
        @(posedge clk) disable iff (reset)
        rdy && decimal |-> op[3:2] != 2'b11
    ) else $error("result_stage: decimal set with logic code %b", op);

endmodule

`default_nettype wire

// File: hdl/alu6502.sv
// alu6502 top level
// Decimal-capable 8-bit style ALU. Logic unit and decimal adder work on
// the operands in parallel, the result stage registers the chosen result
// on each cycle with rdy high and forms the corrected value and the flags,
// one cycle after the operands are taken.
`timescale 1ns/10ps
`default_nettype none

module alu6502 import alu6502_pkg::*; #(
    parameter int DIGITS = 2                    // Two digits, one byte
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rdy,
    input  alu_op_t                      op,
    input  logic [DIGITS*NIBBLE_W-1:0]   a,
    input  logic [DIGITS*NIBBLE_W-1:0]   b,
    input  logic                         ci,
    input  logic                         decimal,
    output logic [DIGITS*NIBBLE_W-1:0]   result,
    output logic                         c,
    output logic                         z,
    output logic                         n,
    output logic                         v
);

    logic [DIGITS*NIBBLE_W-1:0] logic_result;
    logic                       shift_carry;
    logic [DIGITS*NIBBLE_W-1:0] sum;
    logic                       carry_out;
    logic [DIGITS-1:0]          digit_carry;
    logic                       b_msb;

    logic_unit #(.DIGITS(DIGITS)) i_logic_unit (
        .clk          (clk),
        .reset        (reset),
        .a            (a),
        .b            (b),
        .op           (op),
        .ci           (ci),
        .logic_result (logic_result),
        .shift_carry  (shift_carry)
    );

    decimal_adder #(.DIGITS(DIGITS)) i_decimal_adder (
        .a            (a),
        .b            (b),
        .ci           (ci),
        .op           (op),
        .decimal      (decimal),
        .sum          (sum),
        .carry_out    (carry_out),
        .digit_carry  (digit_carry),
        .b_msb        (b_msb)
    );

    result_stage #(.DIGITS(DIGITS)) i_result_stage (
        .clk          (clk),
        .reset        (reset),
        .rdy          (rdy),
        .op           (op),
        .decimal      (decimal),
        .a_msb        (a[DIGITS*NIBBLE_W-1]),  // Sign of A for overflow
        .logic_result (logic_result),
        .shift_carry  (shift_carry),
        .sum          (sum),
        .carry_out    (carry_out),
        .digit_carry  (digit_carry),
        .b_msb        (b_msb),
        .result       (result),
        .c            (c),
        .z            (z),
        .n            (n),
        .v            (v)
    );

endmodule

`default_nettype wire

// File: verification/alu6502_vectors.svh
// alu6502 test vectors
// Directed table for the ALU testbench, applied in order by the table loop.
// Columns: name, op, a, b, ci, decimal, expected result, expected c,
// check n/z/v (only for binary add and subtract)
`ifndef ALU6502_VECTORS_SVH
`define ALU6502_VECTORS_SVH

localparam int NUM_VECTORS = 30;

string        vec_name    [NUM_VECTORS];
alu_op_t      vec_op      [NUM_VECTORS];
logic [W-1:0] vec_a       [NUM_VECTORS];
logic [W-1:0] vec_b       [NUM_VECTORS];
logic         vec_ci      [NUM_VECTORS];
logic         vec_dec     [NUM_VECTORS];
logic [W-1:0] vec_result  [NUM_VECTORS];
logic         vec_c       [NUM_VECTORS];
logic         vec_nzv     [NUM_VECTORS];    // N, Z and V are compared
int           vec_count;

task automatic add_vector(input string name, input alu_op_t op_in, input logic [W-1:0] a_in,
                          input logic [W-1:0] b_in, input logic ci_in, input logic dec_in,
                          input logic [W-1:0] res_in, input logic c_in, input logic nzv_in);
    vec_name[vec_count]   = name;
    vec_op[vec_count]     = op_in;
    vec_a[vec_count]      = a_in;
    vec_b[vec_count]      = b_in;
    vec_ci[vec_count]     = ci_in;
    vec_dec[vec_count]    = dec_in;
    vec_result[vec_count] = res_in;
    vec_c[vec_count]      = c_in;
    vec_nzv[vec_count]    = nzv_in;
    vec_count++;
endtask

task automatic load_vectors();
    vec_count = 0;
    // Binary add, carries and signed overflow
    add_vector("adc_simple",    OP_ADD, 8'h12, 8'h34, 1'b0, 1'b0, 8'h46, 1'b0, 1'b1);
    add_vector("adc_carry_in",  OP_ADD, 8'h12, 8'h34, 1'b1, 1'b0, 8'h47, 1'b0, 1'b1);
    add_vector("adc_carry_out", OP_ADD, 8'hF0, 8'h20, 1'b0, 1'b0, 8'h10, 1'b1, 1'b1);
    add_vector("adc_zero",      OP_ADD, 8'hFF, 8'h01, 1'b0, 1'b0, 8'h00, 1'b1, 1'b1);
    add_vector("adc_pos_ovf",   OP_ADD, 8'h50, 8'h50, 1'b0, 1'b0, 8'hA0, 1'b0, 1'b1);
    add_vector("adc_neg_ovf",   OP_ADD, 8'h90, 8'h90, 1'b0, 1'b0, 8'h20, 1'b1, 1'b1);
    // Binary subtract, c means no borrow
    add_vector("sbc_simple",    OP_SUB, 8'h50, 8'h20, 1'b1, 1'b0, 8'h30, 1'b1, 1'b1);
    add_vector("sbc_borrow",    OP_SUB, 8'h20, 8'h50, 1'b1, 1'b0, 8'hD0, 1'b0, 1'b1);
    add_vector("sbc_borrow_in", OP_SUB, 8'h50, 8'h20, 1'b0, 1'b0, 8'h2F, 1'b1, 1'b1);
    add_vector("sbc_ovf",       OP_SUB, 8'h80, 8'h01, 1'b1, 1'b0, 8'h7F, 1'b1, 1'b1);
    // Compare, subtract with ci set
    add_vector("cmp_equal",     OP_SUB, 8'h42, 8'h42, 1'b1, 1'b0, 8'h00, 1'b1, 1'b1);
    add_vector("cmp_greater",   OP_SUB, 8'h43, 8'h42, 1'b1, 1'b0, 8'h01, 1'b1, 1'b1);
    add_vector("cmp_less",      OP_SUB, 8'h41, 8'h42, 1'b1, 1'b0, 8'hFF, 1'b0, 1'b1);
    // Logic codes, carry always clear
    add_vector("or",            OP_OR,  8'hA5, 8'h0F, 1'b0, 1'b0, 8'hAF, 1'b0, 1'b0);
    add_vector("and",           OP_AND, 8'hA5, 8'h0F, 1'b1, 1'b0, 8'h05, 1'b0, 1'b0);
    add_vector("eor",           OP_EOR, 8'hA5, 8'hFF, 1'b0, 1'b0, 8'h5A, 1'b0, 1'b0);
    add_vector("pass_a",        OP_A,   8'h81, 8'h7E, 1'b1, 1'b0, 8'h81, 1'b0, 1'b0);
    // Shifts left through the adder, right through the logic path
    add_vector("asl",           OP_ROL, 8'h81, 8'h00, 1'b0, 1'b0, 8'h02, 1'b1, 1'b0);
    add_vector("rol",           OP_ROL, 8'h41, 8'h00, 1'b1, 1'b0, 8'h83, 1'b0, 1'b0);
    add_vector("lsr",           OP_SHR, 8'h81, 8'h00, 1'b0, 1'b0, 8'h40, 1'b1, 1'b0);
    add_vector("ror",           OP_SHR, 8'h02, 8'h00, 1'b1, 1'b0, 8'h81, 1'b0, 1'b0);
    // Decimal add, BCD operands
    add_vector("dadc_simple",   OP_ADD, 8'h12, 8'h34, 1'b0, 1'b1, 8'h46, 1'b0, 1'b0);
    add_vector("dadc_digit",    OP_ADD, 8'h45, 8'h38, 1'b0, 1'b1, 8'h83, 1'b0, 1'b0);
    add_vector("dadc_wrap",     OP_ADD, 8'h99, 8'h01, 1'b0, 1'b1, 8'h00, 1'b1, 1'b0);
    add_vector("dadc_carry_in", OP_ADD, 8'h58, 8'h46, 1'b1, 1'b1, 8'h05, 1'b1, 1'b0);
    add_vector("dadc_max",      OP_ADD, 8'h99, 8'h99, 1'b1, 1'b1, 8'h99, 1'b1, 1'b0);
    // Decimal subtract
    add_vector("dsbc_simple",   OP_SUB, 8'h46, 8'h12, 1'b1, 1'b1, 8'h34, 1'b1, 1'b0);
    add_vector("dsbc_digit",    OP_SUB, 8'h40, 8'h13, 1'b1, 1'b1, 8'h27, 1'b1, 1'b0);
    add_vector("dsbc_wrap",     OP_SUB, 8'h12, 8'h21, 1'b1, 1'b1, 8'h91, 1'b0, 1'b0);
    add_vector("dsbc_borrow",   OP_SUB, 8'h50, 8'h25, 1'b0, 1'b1, 8'h24, 1'b1, 1'b0);
endtask

`endif

// File: verification/alu6502_tb.sv
// alu6502 testbench
// Runs the directed vector table, forty random binary add and subtract
// operations, a reset check and a stall check against the ALU, with
// expected values worked out from the binary and decimal arithmetic rules.
`timescale 1ns/10ps
`default_nettype none

module alu6502_tb import alu6502_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int DRIVE_DELAY  = 2;            // Inputs change after the edge
    localparam int SAMPLE_DELAY = 1;            // Outputs settled by then
    localparam int RESET_CYCLES = 3;
    localparam int NUM_RANDOM   = 40;
    localparam int SEED         = 20;
    localparam int W            = 8;

`include "alu6502_vectors.svh"

    localparam int NUM_TESTS  = NUM_VECTORS + NUM_RANDOM + 2;  // Plus reset and stall
    localparam int TIMEOUT_NS = (NUM_TESTS * 4 + RESET_CYCLES) * PERIOD;

    logic         clk;
    logic         reset;
    logic         rdy;
    alu_op_t      op;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic         ci;
    logic         decimal;
    logic [W-1:0] result;
    logic         c;
    logic         z;
    logic         n;
    logic         v;

    int           tests_run;
    int           tests_failed;
    integer       seed;

    alu6502 #(.DIGITS(2)) i_dut (
        .clk     (clk),
        .reset   (reset),
        .rdy     (rdy),
        .op      (op),
        .a       (a),
        .b       (b),
        .ci      (ci),
        .decimal (decimal),
        .result  (result),
        .c       (c),
        .z       (z),
        .n       (n),
        .v       (v)
    );

    always #(PERIOD/2) clk = ~clk;

    // Same-sign operands giving a result of the other sign
    function automatic logic overflow_of(input alu_op_t op_in, input logic [W-1:0] a_in,
                                         input logic [W-1:0] b_in, input logic [W-1:0] res);
        logic [W-1:0] b_eff;
        b_eff = (op_in == OP_SUB) ? ~b_in : b_in;   // Subtract adds inverted b
        return (a_in[W-1] == b_eff[W-1]) && (res[W-1] != a_in[W-1]);
    endfunction

    task automatic expected_binary(input alu_op_t op_in, input logic [W-1:0] a_in,
                                   input logic [W-1:0] b_in, input logic ci_in,
                                   output logic [W-1:0] res, output logic carry);
        logic [W-1:0] b_eff;
        logic [W:0]   total;
        b_eff = (op_in == OP_SUB) ? ~b_in : b_in;
        total = {1'b0, a_in} + {1'b0, b_eff} + {{W{1'b0}}, ci_in};
        res   = total[W-1:0];
        carry = total[W];                       // Ninth bit
    endtask

    // Drive at the drive point, return at the sample point after the edge
    task automatic apply_op(input alu_op_t op_in, input logic [W-1:0] a_in,
                            input logic [W-1:0] b_in, input logic ci_in, input logic dec_in);
        op      = op_in;
        a       = a_in;
        b       = b_in;
        ci      = ci_in;
        decimal = dec_in;
        @(posedge clk);
        #(SAMPLE_DELAY);
    endtask

    task automatic compare_outputs(input string name, input logic [W-1:0] exp_result,
                                   input logic exp_c, input logic check_nzv, input logic exp_n,
                                   input logic exp_z, input logic exp_v, inout bit ok);
        if (result !== exp_result) begin
            $display("FAIL %s: result expected %02h, actual %02h", name, exp_result, result);
            ok = 1'b0;
        end
        if (c !== exp_c) begin
            $display("FAIL %s: c expected %b, actual %b", name, exp_c, c);
            ok = 1'b0;
        end
        if (check_nzv) begin
            if (n !== exp_n) begin
                $display("FAIL %s: n expected %b, actual %b", name, exp_n, n);
                ok = 1'b0;
            end
            if (z !== exp_z) begin
                $display("FAIL %s: z expected %b, actual %b", name, exp_z, z);
                ok = 1'b0;
            end
            if (v !== exp_v) begin
                $display("FAIL %s: v expected %b, actual %b", name, exp_v, v);
                ok = 1'b0;
            end
        end
    endtask

    task automatic record_test(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
        end
    endtask

    initial begin
        bit           ok;
        logic [31:0]  rnd;
        alu_op_t      r_op;
        logic [W-1:0] r_a;
        logic [W-1:0] r_b;
        logic         r_ci;
        logic [W-1:0] exp_res;
        logic         exp_c;

        clk          = 1'b0;
        reset        = 1'b1;
        rdy          = 1'b1;
        op           = OP_A;
        a            = '0;
        b            = '0;
        ci           = 1'b0;
        decimal      = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = SEED;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        // Register cleared by reset
        ok = 1'b1;
        compare_outputs("reset_state", 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, ok);
        record_test("reset_state", ok);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_op(vec_op[i], vec_a[i], vec_b[i], vec_ci[i], vec_dec[i]);
            ok = 1'b1;
            compare_outputs(vec_name[i], vec_result[i], vec_c[i], vec_nzv[i],
                            vec_result[i][W-1], vec_result[i] == '0,
                            overflow_of(vec_op[i], vec_a[i], vec_b[i], vec_result[i]), ok);
            record_test(vec_name[i], ok);
            #(DRIVE_DELAY - SAMPLE_DELAY);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd  = $random(seed);
            r_a  = rnd[7:0];
            r_b  = rnd[15:8];
            r_ci = rnd[16];
            r_op = rnd[17] ? OP_SUB : OP_ADD;
            expected_binary(r_op, r_a, r_b, r_ci, exp_res, exp_c);
            apply_op(r_op, r_a, r_b, r_ci, 1'b0);
            ok = 1'b1;
            compare_outputs($sformatf("random_%0d", i), exp_res, exp_c, 1'b1, exp_res[W-1],
                            exp_res == '0, overflow_of(r_op, r_a, r_b, exp_res), ok);
            record_test($sformatf("random_%0d", i), ok);
            #(DRIVE_DELAY - SAMPLE_DELAY);
        end

        // 0x25 + 0x0B = 0x30 is held through the stall
        ok = 1'b1;
        apply_op(OP_ADD, 8'h25, 8'h0B, 1'b0, 1'b0);
        compare_outputs("stall_hold", 8'h30, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, ok);
        #(DRIVE_DELAY - SAMPLE_DELAY);
        rdy = 1'b0;
        for (int i = 0; i < 3; i++) begin
            apply_op(OP_SUB, W'(8'h11 * (i + 1)), 8'hC3, 1'b1, 1'b0);    // Ignored while stalled
            compare_outputs("stall_hold", 8'h30, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, ok);
            #(DRIVE_DELAY - SAMPLE_DELAY);
        end
        rdy = 1'b1;
        record_test("stall_hold", ok);

        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog allows four periods per test plus reset
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: alu6502.f
+incdir+verification
common/alu6502_pkg.sv
hdl/logic_unit.sv
decimal_adder/decimal_adder.sv
result_stage/result_stage.sv
hdl/alu6502.sv
verification/alu6502_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the alu6502 testbench with Verilator and run it.
# Exits with status 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f alu6502.f \
    --top-module alu6502_tb \
    --Mdir obj_dir \
    -o alu6502_sim \
    || { echo "Build failed"; exit 1; }

output=$(./obj_dir/alu6502_sim)
echo "$output"

echo "$output" | grep -qx "Verification passed" && exit 0 || exit 1
